/* hw/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Datapath widths
`define LSU_WORD_WIDTH      32
`define LSU_BYTE_SEL_WIDTH  4

// On-chip data RAM region, inclusive byte addresses
`define LSU_DRAM_BASE       32'h0000_0000
`define LSU_DRAM_LIMIT      32'h0000_0FFF

// Word index into the data RAM, 1024 words
`define LSU_DRAM_ADDR_WIDTH 10

`endif

/* hw/lsu_pkg.sv */
`include "lsu_params.svh"

package lsu_pkg;

   // Data or address word
   typedef logic [`LSU_WORD_WIDTH-1:0] word_t;

   // Byte enables, bit 3 is the lane at byte address 0 (bits 31:24)
   typedef logic [`LSU_BYTE_SEL_WIDTH-1:0] byte_sel_t;

   // Access size code as decoded by the pipeline
   typedef logic [1:0] size_t;

   // Word index into the data RAM
   typedef logic [`LSU_DRAM_ADDR_WIDTH-1:0] dram_addr_t;

   localparam size_t SIZE_BYTE  = 2'b00;
   localparam size_t SIZE_WORD  = 2'b10;
   localparam size_t SIZE_HWORD = 2'b11;

endpackage

/* hw/lsu_x_stage.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_x_stage import lsu_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  logic      stall_m_i,
   input  size_t     size_x_i,
   input  logic      sign_extend_x_i,
   input  word_t     store_operand_x_i,
   input  word_t     address_x_i,
   output word_t     store_data_m_o,
   output byte_sel_t byte_enable_m_o,
   output size_t     size_m_o,
   output logic      sign_extend_m_o,
   output logic      dram_select_x_o,
   output logic      dram_select_m_o,
   output logic      wb_select_x_o,
   output logic      wb_select_m_o
);

   word_t     store_data_x;
   byte_sel_t byte_enable_x;
   logic [1:0] addr_lo_m;      // Low address bits, kept for the alignment check

   // Replicate the operand so each lane carries the store value
   always_comb
   begin
      case (size_x_i)
         SIZE_BYTE:  store_data_x = {4{store_operand_x_i[7:0]}};
         SIZE_HWORD: store_data_x = {2{store_operand_x_i[15:0]}};
         default:    store_data_x = store_operand_x_i;
      endcase
   end

   // Big-endian enables: offset 0 is the top lane
   always_comb
   begin
      case (size_x_i)
         SIZE_BYTE:  byte_enable_x = byte_sel_t'(4'b1000 >> address_x_i[1:0]);
         SIZE_HWORD: byte_enable_x = address_x_i[1] ? 4'b0011 : 4'b1100;
         SIZE_WORD:  byte_enable_x = 4'b1111;
         default:    byte_enable_x = 4'b0000;   // Undefined size, nothing written
      endcase
   end

   // Region decode, everything outside the RAM window goes to the bus
   assign dram_select_x_o = (address_x_i >= `LSU_DRAM_BASE) &&
                            (address_x_i <= `LSU_DRAM_LIMIT);
   assign wb_select_x_o   = !dram_select_x_o;

   // X/M pipeline registers
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         byte_enable_m_o <= '0;
         size_m_o        <= SIZE_BYTE;
         sign_extend_m_o <= 1'b0;
         dram_select_m_o <= 1'b0;
         wb_select_m_o   <= 1'b0;
         addr_lo_m       <= 2'b00;
      end
      else if (!stall_m_i)
      begin
         byte_enable_m_o <= byte_enable_x;
         size_m_o        <= size_x_i;
         sign_extend_m_o <= sign_extend_x_i;
         dram_select_m_o <= dram_select_x_o;
         wb_select_m_o   <= wb_select_x_o;
         addr_lo_m       <= address_x_i[1:0];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!stall_m_i)
         store_data_m_o <= store_data_x;
   end

   // Misaligned halfword or word access leaving M
   a_aligned_m : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !stall_m_i |->
         !((size_m_o == SIZE_HWORD) && addr_lo_m[0]) &&
         !((size_m_o == SIZE_WORD) && (addr_lo_m != 2'b00)))
      else $error("Misaligned access in M, size %b offset %b", size_m_o, addr_lo_m);

endmodule

/* hw/lsu_data_ram.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_data_ram import lsu_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  logic      stall_x_i,
   input  logic      stall_m_i,
   input  logic      load_x_i,
   input  logic      store_x_i,
   input  logic      store_q_m_i,
   input  word_t     address_x_i,
   input  word_t     address_m_i,
   input  logic      dram_select_m_i,
   input  word_t     store_data_m_i,
   input  byte_sel_t byte_enable_m_i,
   output word_t     dram_data_m_o
);

   word_t      mem [0:(1 << `LSU_DRAM_ADDR_WIDTH)-1];
   dram_addr_t rd_idx;
   dram_addr_t wr_idx;
   word_t      rd_data_q;       // Array output, valid in M
   word_t      store_merged;    // Store bytes over the current M word
   word_t      bypass_data_q;
   logic       bypass_en_q;
   logic       write_en;
   logic       x_access;
   logic       bypass_hit;

   assign rd_idx   = address_x_i[`LSU_DRAM_ADDR_WIDTH+1:2];
   assign wr_idx   = address_m_i[`LSU_DRAM_ADDR_WIDTH+1:2];
   assign x_access = load_x_i || store_x_i;
   assign write_en = store_q_m_i && dram_select_m_i && !stall_m_i;

   // A store in M and an access in X on the same word on the same edge
   assign bypass_hit = write_en && x_access && !stall_x_i &&
                       (address_x_i[`LSU_WORD_WIDTH-1:2] == address_m_i[`LSU_WORD_WIDTH-1:2]);

   assign dram_data_m_o = bypass_en_q ? bypass_data_q : rd_data_q;

   // Read-merge-write, untouched lanes keep the word read in X
   always_comb
   begin
      for (int i = 0; i < `LSU_BYTE_SEL_WIDTH; i++)
      begin
         store_merged[8*i +: 8] = byte_enable_m_i[i] ? store_data_m_i[8*i +: 8]
                                                     : dram_data_m_o[8*i +: 8];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (write_en)
         mem[wr_idx] <= store_merged;
   end

   // Read port, sampled as the access moves from X to M
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         rd_data_q <= '0;
      else if (!stall_x_i && x_access)
         rd_data_q <= mem[rd_idx];
   end

   // The array returns the old word on a same-edge write, so hold the new one
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         bypass_en_q <= 1'b0;
      else if (!stall_x_i)
         bypass_en_q <= bypass_hit;
   end

   always_ff @(posedge clk_i)
   begin
      if (bypass_hit)
         bypass_data_q <= store_merged;
   end

   // M-stage selects are still cleared one edge out of reset
   a_no_bypass_after_reset : assert property (@(posedge clk_i)
      $rose(arst_n_i) |=> !bypass_en_q)
      else $error("Data RAM bypass enabled right after reset");

endmodule

/* hw/lsu_wb_master.sv */
`timescale 1ns/10ps

module lsu_wb_master import lsu_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  logic      stall_x_i,
   input  logic      stall_m_i,
   input  logic      kill_m_i,
   input  logic      load_q_x_i,
   input  logic      load_q_m_i,
   input  logic      store_q_m_i,
   input  logic      wb_select_x_i,
   input  logic      wb_select_m_i,
   input  word_t     address_m_i,
   input  word_t     store_data_m_i,
   input  byte_sel_t byte_enable_m_i,
   input  word_t     d_dat_i,
   input  logic      d_ack_i,
   input  logic      d_err_i,
   output word_t     wb_data_m_o,
   output logic      stall_wb_load_o,
   output word_t     d_dat_o,
   output word_t     d_adr_o,
   output byte_sel_t d_sel_o,
   output logic      d_cyc_o,
   output logic      d_stb_o,
   output logic      d_we_o
);

   logic load_complete;    // Bus load in M already has its data
   logic cyc_done;
   logic start_store;
   logic start_load;

   assign cyc_done    = d_cyc_o && (d_ack_i || d_err_i);
   assign start_store = !d_cyc_o && store_q_m_i && wb_select_m_i && !stall_m_i;
   assign start_load  = !d_cyc_o && load_q_m_i && wb_select_m_i && !load_complete &&
                        !kill_m_i;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         d_cyc_o         <= 1'b0;
         d_stb_o         <= 1'b0;
         d_we_o          <= 1'b0;
         d_dat_o         <= '0;
         d_adr_o         <= '0;
         d_sel_o         <= '0;
         wb_data_m_o     <= '0;
         load_complete   <= 1'b0;
         stall_wb_load_o <= 1'b0;
      end
      else
      begin
         if (cyc_done)
         begin
            d_cyc_o       <= 1'b0;
            d_stb_o       <= 1'b0;
            wb_data_m_o   <= d_dat_i;
            load_complete <= !d_we_o;   // A finished store must not mark a load done
         end
         else if (start_store)
         begin
            d_dat_o <= store_data_m_i;
            d_adr_o <= address_m_i;
            d_sel_o <= byte_enable_m_i;
            d_we_o  <= 1'b1;
            d_cyc_o <= 1'b1;
            d_stb_o <= 1'b1;
         end
         else if (start_load)
         begin
            d_adr_o         <= address_m_i;
            d_sel_o         <= byte_enable_m_i;
            d_we_o          <= 1'b0;
            d_cyc_o         <= 1'b1;
            d_stb_o         <= 1'b1;
            stall_wb_load_o <= 1'b0;    // Cycle held open now keeps M stalled
         end

         // Instruction leaves M
         if (!stall_m_i)
            load_complete <= 1'b0;

         // Bus load entering M, hold it there until the read is issued
         if (load_q_x_i && wb_select_x_i && !stall_x_i)
            stall_wb_load_o <= 1'b1;

         if (kill_m_i)
            stall_wb_load_o <= 1'b0;
      end
   end

   a_stb_is_cyc : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      d_stb_o == d_cyc_o)
      else $error("Wishbone stb and cyc differ");

   // Request held stable until the slave answers
   a_req_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      d_cyc_o && !d_ack_i && !d_err_i |=>
         d_cyc_o && $stable(d_adr_o) && $stable(d_we_o) && $stable(d_sel_o))
      else $error("Wishbone request changed before ack");

endmodule

/* hw/lsu_load_align.sv */
`timescale 1ns/10ps

module lsu_load_align import lsu_pkg::*; (
   input  logic  clk_i,
   input  logic  arst_n_i,
   input  logic  wb_select_m_i,
   input  word_t wb_data_m_i,
   input  word_t dram_data_m_i,
   input  size_t size_m_i,
   input  logic  sign_extend_m_i,
   input  word_t address_m_i,
   output word_t load_data_w_o
);

   word_t       data_w;
   size_t       size_w;
   logic        sign_extend_w;
   logic [1:0]  addr_w;
   logic [7:0]  byte_w;
   logic [15:0] half_w;

   // M/W registers
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         data_w        <= '0;
         size_w        <= SIZE_BYTE;
         sign_extend_w <= 1'b0;
         addr_w        <= 2'b00;
      end
      else
      begin
         data_w        <= wb_select_m_i ? wb_data_m_i : dram_data_m_i;
         size_w        <= size_m_i;
         sign_extend_w <= sign_extend_m_i;
         addr_w        <= address_m_i[1:0];
      end
   end

   // Offset 0 sits in the top lane
   assign byte_w = data_w[{~addr_w, 3'b000} +: 8];
   assign half_w = addr_w[1] ? data_w[15:0] : data_w[31:16];

   always_comb
   begin
      case (size_w)
         SIZE_BYTE:  load_data_w_o = {{24{sign_extend_w & byte_w[7]}}, byte_w};
         SIZE_HWORD: load_data_w_o = {{16{sign_extend_w & half_w[15]}}, half_w};
         default:    load_data_w_o = data_w;    // Full word
      endcase
   end

endmodule

/* hw/lsu_top.sv */
`timescale 1ns/10ps

module lsu_top import lsu_pkg::*; (
   input  logic      clk_i,
   input  logic      arst_n_i,
   // Pipeline side
   input  logic      stall_x_i,
   input  logic      stall_m_i,
   input  logic      kill_m_i,
   input  logic      load_x_i,
   input  logic      store_x_i,
   input  logic      load_q_x_i,
   input  logic      load_q_m_i,
   input  logic      store_q_m_i,
   input  size_t     size_x_i,
   input  logic      sign_extend_x_i,
   input  word_t     store_operand_x_i,
   input  word_t     address_x_i,
   input  word_t     address_m_i,
   output word_t     load_data_w_o,
   output logic      stall_wb_load_o,
   // Wishbone master
   input  word_t     d_dat_i,
   input  logic      d_ack_i,
   input  logic      d_err_i,
   output word_t     d_dat_o,
   output word_t     d_adr_o,
   output byte_sel_t d_sel_o,
   output logic      d_cyc_o,
   output logic      d_stb_o,
   output logic      d_we_o
);

   word_t     store_data_m;
   byte_sel_t byte_enable_m;
   size_t     size_m;
   logic      sign_extend_m;
   logic      dram_select_m;
   logic      wb_select_x;
   logic      wb_select_m;
   word_t     dram_data_m;
   word_t     wb_data_m;

   lsu_x_stage u_x_stage (
      .clk_i             (clk_i),
      .arst_n_i          (arst_n_i),
      .stall_m_i         (stall_m_i),
      .size_x_i          (size_x_i),
      .sign_extend_x_i   (sign_extend_x_i),
      .store_operand_x_i (store_operand_x_i),
      .address_x_i       (address_x_i),
      .store_data_m_o    (store_data_m),
      .byte_enable_m_o   (byte_enable_m),
      .size_m_o          (size_m),
      .sign_extend_m_o   (sign_extend_m),
      .dram_select_x_o   (),              // Complement of wb_select_x
      .dram_select_m_o   (dram_select_m),
      .wb_select_x_o     (wb_select_x),
      .wb_select_m_o     (wb_select_m)
   );

   lsu_data_ram u_data_ram (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .stall_x_i       (stall_x_i),
      .stall_m_i       (stall_m_i),
      .load_x_i        (load_x_i),
      .store_x_i       (store_x_i),
      .store_q_m_i     (store_q_m_i),
      .address_x_i     (address_x_i),
      .address_m_i     (address_m_i),
      .dram_select_m_i (dram_select_m),
      .store_data_m_i  (store_data_m),
      .byte_enable_m_i (byte_enable_m),
      .dram_data_m_o   (dram_data_m)
   );

   lsu_wb_master u_wb_master (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .stall_x_i       (stall_x_i),
      .stall_m_i       (stall_m_i),
      .kill_m_i        (kill_m_i),
      .load_q_x_i      (load_q_x_i),
      .load_q_m_i      (load_q_m_i),
      .store_q_m_i     (store_q_m_i),
      .wb_select_x_i   (wb_select_x),
      .wb_select_m_i   (wb_select_m),
      .address_m_i     (address_m_i),
      .store_data_m_i  (store_data_m),
      .byte_enable_m_i (byte_enable_m),
      .d_dat_i         (d_dat_i),
      .d_ack_i         (d_ack_i),
      .d_err_i         (d_err_i),
      .wb_data_m_o     (wb_data_m),
      .stall_wb_load_o (stall_wb_load_o),
      .d_dat_o         (d_dat_o),
      .d_adr_o         (d_adr_o),
      .d_sel_o         (d_sel_o),
      .d_cyc_o         (d_cyc_o),
      .d_stb_o         (d_stb_o),
      .d_we_o          (d_we_o)
   );

   lsu_load_align u_load_align (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .wb_select_m_i   (wb_select_m),
      .wb_data_m_i     (wb_data_m),
      .dram_data_m_i   (dram_data_m),
      .size_m_i        (size_m),
      .sign_extend_m_i (sign_extend_m),
      .address_m_i     (address_m_i),
      .load_data_w_o   (load_data_w_o)
   );

endmodule

/* sim/tb_lsu.sv */
`timescale 1ns/10ps
`include "lsu_params.svh"

module tb_lsu import lsu_pkg::*; ();

   localparam int    TIMEOUT  = 40;                       // Cycles allowed per wait
   localparam word_t BUS_BASE = `LSU_DRAM_LIMIT + 32'h1;   // First address outside the RAM

   logic      clk_i = 1'b0;
   logic      arst_n_i;
   logic      stall_x_i, stall_m_i;
   logic      kill_m_i, load_x_i, store_x_i, load_q_x_i, sign_extend_x_i;
   logic      load_q_m_i = 1'b0;
   logic      store_q_m_i = 1'b0;
   size_t     size_x_i;
   word_t     store_operand_x_i, address_x_i;
   word_t     address_m_i = '0;
   word_t     load_data_w_o, d_dat_o, d_adr_o;
   word_t     d_dat_i = '0;
   logic      d_ack_i = 1'b0;
   logic      d_err_i = 1'b0;
   logic      stall_wb_load_o, d_cyc_o, d_stb_o, d_we_o;
   byte_sel_t d_sel_o;

   word_t  slave_mem [0:63];
   word_t  ram_model [0:(1 << `LSU_DRAM_ADDR_WIDTH)-1];
   int     wait_cnt = 0;
   logic   err_mode = 1'b0;
   integer seed = 32'hca8f;
   int     errors = 0;
   int     checks = 0;

   lsu_top u_dut (.*);

   always #20 clk_i = ~clk_i;

   // Pipeline model, both stages hold while a bus load is pending or a cycle is open
   assign stall_m_i = stall_wb_load_o | d_cyc_o;
   assign stall_x_i = stall_m_i;

   always @(posedge clk_i)
   begin
      if (!arst_n_i)
      begin
         load_q_m_i  <= 1'b0;
         store_q_m_i <= 1'b0;
      end
      else if (!stall_m_i)
      begin
         address_m_i <= address_x_i;
         load_q_m_i  <= load_q_x_i;
         store_q_m_i <= store_x_i;
      end
      else if (kill_m_i)
      begin
         load_q_m_i  <= 1'b0;    // Killed access drops out of M
         store_q_m_i <= 1'b0;
      end
   end

   // Wishbone slave with 0 to 3 wait cycles
   always @(posedge clk_i)
   begin
      d_ack_i <= 1'b0;
      d_err_i <= 1'b0;
      if (arst_n_i && d_cyc_o && d_stb_o && !d_ack_i && !d_err_i)
      begin
         if (wait_cnt > 0)
            wait_cnt <= wait_cnt - 1;
         else
         begin
            wait_cnt <= {$random(seed)} % 4;
            d_ack_i  <= !err_mode;
            d_err_i  <= err_mode;
            d_dat_i  <= slave_mem[d_adr_o[7:2]];
            for (int l = 0; l < 4; l++)
               if (d_we_o && d_sel_o[l] && !err_mode)
                  slave_mem[d_adr_o[7:2]][8*l +: 8] <= d_dat_o[8*l +: 8];
         end
      end
   end

   function automatic int size_bytes(input size_t sz);
      case (sz)
         SIZE_BYTE:  return 1;
         SIZE_HWORD: return 2;
         default:    return 4;
      endcase
   endfunction

   // Byte address l lives in bits 8*(3-l)+7 down to 8*(3-l)
   function automatic byte_sel_t lanes_of(input size_t sz, input logic [1:0] off);
      byte_sel_t sel;
      for (int l = 0; l < 4; l++)
         sel[3-l] = (l >= off) && (l < off + size_bytes(sz));
      return sel;
   endfunction

   function automatic word_t replicate(input size_t sz, input word_t op);
      word_t w;
      for (int l = 0; l < 4; l++)
         w[8*(3-l) +: 8] = op[8*((3-l) % size_bytes(sz)) +: 8];
      return w;
   endfunction

   // Addressed bytes moved to the top, then shifted down with the chosen fill
   function automatic word_t extend(input word_t w, input size_t sz, input logic [1:0] off,
                                    input logic sx);
      word_t top;
      word_t res;
      int    n;
      n   = size_bytes(sz);
      top = w << (8*off);
      res = top >> (32 - 8*n);
      if (sx && top[31] && n < 4)
         res = res | (32'hFFFF_FFFF << (8*n));
      return res;
   endfunction

   task automatic check(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   function automatic logic probe(input string name);
      case (name)
         "d_cyc_o":         return d_cyc_o;
         "stall_wb_load_o": return stall_wb_load_o;
         "stall_m_i":       return stall_m_i;
         default:           return d_ack_i | d_err_i;   // Slave response
      endcase
   endfunction

   // Polls on falling edges
   task automatic wait_level(input string name, input logic level);
      int n;
      n = 0;
      while (probe(name) !== level && n < TIMEOUT)
      begin
         @(negedge clk_i);
         n++;
      end
      if (probe(name) !== level)
      begin
         errors++;
         $display("Timeout at %0t ns: %s never went to %b", $time, name, level);
      end
   endtask

   task automatic drive_x(input logic ld, input logic st, input size_t sz, input logic sx,
                          input word_t adr, input word_t op);
      @(posedge clk_i);
      load_x_i          <= ld;
      load_q_x_i        <= ld;
      store_x_i         <= st;
      size_x_i          <= sz;
      sign_extend_x_i   <= sx;
      address_x_i       <= adr;
      store_operand_x_i <= op;
   endtask

   task automatic idle_x();
      @(posedge clk_i);
      load_x_i   <= 1'b0;
      load_q_x_i <= 1'b0;
      store_x_i  <= 1'b0;
      size_x_i   <= SIZE_BYTE;     // Legal at any offset
   endtask

   task automatic check_idle();
      check("{d_cyc_o,d_stb_o,d_we_o,stall_wb_load_o}",
            {d_cyc_o, d_stb_o, d_we_o, stall_wb_load_o}, 0);
      check("load_data_w_o", load_data_w_o, 0);
   endtask

   task automatic bus_store(input size_t sz, input word_t adr, input word_t op);
      drive_x(1'b0, 1'b1, sz, 1'b0, adr, op);
      idle_x();
      wait_level("d_cyc_o", 1'b1);
      check("d_adr_o", d_adr_o, adr);
      check("d_we_o", d_we_o, 1);
      check("d_sel_o", d_sel_o, lanes_of(sz, adr[1:0]));
      check("d_dat_o", d_dat_o, replicate(sz, op));
      wait_level("response", 1'b1);
      @(negedge clk_i);
      check("d_cyc_o", d_cyc_o, 0);   // Cycle closes on the response edge
   endtask

   task automatic bus_load(input size_t sz, input word_t adr, input logic sx);
      word_t exp;
      exp = extend(slave_mem[adr[7:2]], sz, adr[1:0], sx);
      drive_x(1'b1, 1'b0, sz, sx, adr, '0);
      idle_x();
      @(negedge clk_i);
      check("stall_wb_load_o", stall_wb_load_o, 1);
      wait_level("stall_wb_load_o", 1'b0);
      check("d_cyc_o", d_cyc_o, 1);    // Read issued as the request drops
      wait_level("stall_m_i", 1'b0);
      @(posedge clk_i);                 // Load leaves M
      @(negedge clk_i);
      check("load_data_w_o", load_data_w_o, exp);
   endtask

   // Store then load after gap idle cycles; gap 0 goes through the bypass
   task automatic ram_case(input size_t st_sz, input word_t st_adr, input word_t op,
                           input size_t ld_sz, input word_t ld_adr, input logic sx,
                           input int gap);
      word_t     exp;
      byte_sel_t sel;
      word_t     lanes;
      sel   = lanes_of(st_sz, st_adr[1:0]);
      lanes = replicate(st_sz, op);
      for (int b = 0; b < 4; b++)
         if (sel[b])
            ram_model[st_adr[11:2]][8*b +: 8] = lanes[8*b +: 8];
      exp = extend(ram_model[ld_adr[11:2]], ld_sz, ld_adr[1:0], sx);
      drive_x(1'b0, 1'b1, st_sz, 1'b0, st_adr, op);
      repeat (gap) idle_x();
      drive_x(1'b1, 1'b0, ld_sz, sx, ld_adr, '0);
      idle_x();
      @(posedge clk_i);
      @(negedge clk_i);
      check("load_data_w_o", load_data_w_o, exp);
      check("d_cyc_o", d_cyc_o, 0);
   endtask

   task automatic killed_load(input word_t adr);
      drive_x(1'b1, 1'b0, SIZE_WORD, 1'b0, adr, '0);
      idle_x();
      kill_m_i <= 1'b1;
      @(negedge clk_i);
      check("stall_wb_load_o", stall_wb_load_o, 1);
      @(posedge clk_i);
      kill_m_i <= 1'b0;
      @(negedge clk_i);
      check("stall_wb_load_o", stall_wb_load_o, 0);
      check("d_cyc_o", d_cyc_o, 0);
   endtask

   initial
   begin
      size_t sz;
      word_t adr;
      int    pick;
      arst_n_i          = 1'b0;
      kill_m_i          = 1'b0;
      load_x_i          = 1'b0;
      load_q_x_i        = 1'b0;
      store_x_i         = 1'b0;
      sign_extend_x_i   = 1'b0;
      size_x_i          = SIZE_BYTE;
      store_operand_x_i = '0;
      address_x_i       = '0;
      for (int i = 0; i < 64; i++)
         slave_mem[i] = (i * 32'h0419_2D6B) ^ 32'hA5C3_F00F;

      repeat (5)
      begin
         @(negedge clk_i);
         check_idle();
      end
      @(posedge clk_i);
      arst_n_i <= 1'b1;
      @(negedge clk_i);
      check_idle();

      for (int k = 0; k < 12; k++)
      begin
         pick = {$random(seed)} % 3;
         sz   = (pick == 0) ? SIZE_BYTE : (pick == 1) ? SIZE_HWORD : SIZE_WORD;
         adr  = BUS_BASE + {$random(seed)} % 256;
         adr[0] = adr[0] & (sz == SIZE_BYTE);
         adr[1] = adr[1] & (sz != SIZE_WORD);
         bus_store(sz, adr, $random(seed));
      end

      // Every offset with and without sign extension
      for (int k = 0; k < 8; k++)
      begin
         adr = BUS_BASE + 32'h80 + 8*k + (k % 4);
         bus_load(SIZE_BYTE, adr, k >= 4);
         bus_load(SIZE_HWORD, {adr[31:2], adr[1], 1'b0}, k >= 4);
         bus_load(SIZE_WORD, {adr[31:2], 2'b00}, k >= 4);
      end

      ram_case(SIZE_WORD,  32'h100, 32'h1234_5678, SIZE_WORD,  32'h100, 1'b0, 0);
      ram_case(SIZE_BYTE,  32'h101, 32'h0000_00C3, SIZE_WORD,  32'h100, 1'b0, 2);
      ram_case(SIZE_HWORD, 32'h102, 32'h0000_9ABC, SIZE_BYTE,  32'h103, 1'b1, 0);
      ram_case(SIZE_WORD,  32'h7F8, 32'h8001_7F02, SIZE_HWORD, 32'h7F8, 1'b1, 0);
      ram_case(SIZE_BYTE,  32'h7FB, 32'h0000_0085, SIZE_HWORD, 32'h7FA, 1'b1, 3);
      ram_case(SIZE_HWORD, 32'h7F8, 32'h0000_F00D, SIZE_BYTE,  32'h7F9, 1'b0, 1);
      ram_case(SIZE_WORD,  32'hFFC, 32'hC0DE_4A11, SIZE_BYTE,  32'hFFC, 1'b1, 0);

      err_mode = 1'b1;
      bus_store(SIZE_WORD, BUS_BASE + 32'h40, 32'hDEAD_BEEF);
      err_mode = 1'b0;
      killed_load(BUS_BASE + 32'h44);
      bus_load(SIZE_WORD, BUS_BASE + 32'h48, 1'b0);   // Bus still usable afterwards

      @(negedge clk_i);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

/* list.f */
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_x_stage.sv
hw/lsu_data_ram.sv
hw/lsu_wb_master.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
sim/tb_lsu.sv
